//--- sim.f
+incdir+hdl
hdl/cdc_fifo_pkg.sv
hdl/cdc_fifo_gray_sync.sv
hdl/cdc_fifo_push_flag_mgr.sv
hdl/cdc_fifo_pop_flag_mgr.sv
hdl/cdc_fifo_storage.sv
hdl/cdc_fifo.sv
verification/cdc_fifo_tb.sv

//--- Makefile
# Verilator build for the dual-clock FIFO testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= cdc_fifo_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard hdl/*.sv hdl/*.svh verification/*.sv)
PASS_MSG = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, a missing pass line is a failure
run: compile
	-$(SIM_BIN) | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/cdc_fifo_tb.sv
`timescale 1ns/10ps
`include "cdc_fifo_macros.svh"

module cdc_fifo_tb
  import cdc_fifo_pkg::*;
();

  localparam int depth         = `CDC_FIFO_DEPTH;
  localparam int log_bits      = 10;
  localparam int pop_period_ns = 34;

  // Transactions per test, used to size the watchdog
  localparam int fill_txns   = 2 * depth;
  localparam int drain_txns  = depth;
  localparam int empty_txns  = 4;
  localparam int random_txns = 500;
  localparam int reset_txns  = 2 * depth;
  localparam longint watchdog_ns =
    longint'(fill_txns + drain_txns + empty_txns + random_txns + reset_txns) *
    pop_period_ns * 8;

  logic           push_clk;
  logic           pop_clk;
  // Low from the very start, before any process runs
  logic           rst_n = 1'b0;
  logic           push;
  logic           pop;
  cdc_fifo_word_t push_data;
  cdc_fifo_word_t pop_data;
  push_status_t   push_stat;
  pop_status_t    pop_stat;

  // Scoreboard, every accepted push in order
  cdc_fifo_word_t pushed_log [1 << log_bits];
  logic [15:0]    push_total;
  logic [15:0]    pop_total;
  logic [15:0]    sb_size;
  cdc_fifo_word_t exp_head;

  // Edges seen since rst_n released, strobes count only from two on
  logic [1:0]     push_edges;
  logic [1:0]     pop_edges;
  logic           push_fire;
  logic           pop_fire;
  logic           check_full;
  logic           check_empty;

  string test_name;
  int    error_count;
  int    errors_at_start;
  int    passed_tests;
  int    failed_tests;

  cdc_fifo dut (
    .rst_n     (rst_n),
    .push_clk  (push_clk),
    .push      (push),
    .push_data (push_data),
    .push_stat (push_stat),
    .pop_clk   (pop_clk),
    .pop       (pop),
    .pop_data  (pop_data),
    .pop_stat  (pop_stat)
  );

  always #10 push_clk = ~push_clk;
  always #17 pop_clk = ~pop_clk;

  assign push_fire = push && !push_stat.full && (push_edges == 2'd2);
  assign pop_fire  = pop && !pop_stat.empty && (pop_edges == 2'd2);
  assign sb_size   = push_total - pop_total;
  assign exp_head  = pushed_log[pop_total[log_bits-1:0]];

  always @(posedge push_clk or negedge rst_n) begin
    if (!rst_n) begin
      push_edges <= 2'd0;
      push_total <= 16'd0;
    end else begin
      if (push_edges != 2'd2) begin
        push_edges <= push_edges + 2'd1;
      end
      if (push_fire) begin
        pushed_log[push_total[log_bits-1:0]] <= push_data;
        push_total <= push_total + 16'd1;
      end
    end
  end

  always @(posedge pop_clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_edges <= 2'd0;
      pop_total <= 16'd0;
    end else begin
      if (pop_edges != 2'd2) begin
        pop_edges <= pop_edges + 2'd1;
      end
      if (pop_fire) begin
        pop_total <= pop_total + 16'd1;
      end
    end
  end

  task automatic note_error(string what, longint expected, longint actual);
    $display("error: test %s, %s: expected %0h, actual %0h",
             test_name, what, expected, actual);
    error_count++;
  endtask

  pop_order_a: assert property (
    @(posedge pop_clk) disable iff (!rst_n)
    pop_fire |-> pop_data == exp_head
  ) else note_error("pop data", longint'(exp_head), longint'(pop_data));

  // Pop side may lag the true occupancy but never run ahead of it
  pop_items_bound_a: assert property (
    @(posedge pop_clk) disable iff (!rst_n)
    16'(pop_stat.items) <= sb_size
  ) else note_error("pop items at most", longint'(sb_size), longint'(pop_stat.items));

  push_items_bound_a: assert property (
    @(posedge push_clk) disable iff (!rst_n)
    16'(push_stat.items) >= sb_size
  ) else note_error("push items at least", longint'(sb_size), longint'(push_stat.items));

  pop_items_depth_a: assert property (
    @(posedge pop_clk) disable iff (!rst_n)
    pop_stat.items <= count_t'(depth)
  ) else note_error("pop items at most", longint'(depth), longint'(pop_stat.items));

  push_items_depth_a: assert property (
    @(posedge push_clk) disable iff (!rst_n)
    push_stat.items <= count_t'(depth)
  ) else note_error("push items at most", longint'(depth), longint'(push_stat.items));

  full_status_a: assert property (
    @(posedge push_clk) disable iff (!rst_n)
    check_full |-> push_stat == {count_t'(depth), 1'b1}
  ) else note_error("push status when full", longint'({count_t'(depth), 1'b1}),
                    longint'(push_stat));

  empty_status_a: assert property (
    @(posedge pop_clk) disable iff (!rst_n)
    check_empty |-> pop_stat == {count_t'(0), 1'b1}
  ) else note_error("pop status when empty", 1, longint'(pop_stat));

  // Also holds while rst_n is low
  push_reset_state_a: assert property (
    @(posedge push_clk)
    (push_edges != 2'd2) |-> push_stat == {count_t'(0), 1'b0}
  ) else note_error("push status in reset", 0, longint'(push_stat));

  pop_reset_state_a: assert property (
    @(posedge pop_clk)
    (pop_edges != 2'd2) |-> pop_stat == {count_t'(0), 1'b1}
  ) else note_error("pop status in reset", 1, longint'(pop_stat));

  function automatic cdc_fifo_word_t make_word(logic [3:0] tag);
    cdc_fifo_word_t w;
    w.tag  = tag;
    w.data = `CDC_FIFO_DATA_WIDTH'($urandom);
    return w;
  endfunction

  task automatic begin_test(string name);
    test_name       = name;
    errors_at_start = error_count;
  endtask

  task automatic finish_test();
    int errors;
    errors = error_count - errors_at_start;
    if (errors == 0) begin
      passed_tests++;
      $display("test %s: passed", test_name);
    end else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", test_name, errors);
    end
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (10) @(negedge push_clk);
    rst_n = 1'b1;
  endtask

  // Strobes until count more pushes were accepted
  task automatic push_items(int count, logic [3:0] tag);
    logic [15:0] target;
    target = push_total + 16'(count);
    @(negedge push_clk);
    while (push_total != target) begin
      push      = 1'b1;
      push_data = make_word(tag);
      @(negedge push_clk);
    end
    push = 1'b0;
  endtask

  task automatic strobe_push(int cycles, logic [3:0] tag);
    repeat (cycles) begin
      @(negedge push_clk);
      push      = 1'b1;
      push_data = make_word(tag);
    end
  endtask

  task automatic drain_all();
    @(negedge pop_clk);
    while (pop_total != push_total) begin
      pop = 1'b1;
      @(negedge pop_clk);
    end
    pop = 1'b0;
  endtask

  task automatic fill_to_full();
    begin_test("fill_to_full");
    push_items(depth, 4'h1);
    // These land on a full FIFO and must be refused
    strobe_push(4, 4'he);
    check_full = 1'b1;
    strobe_push(4, 4'he);
    @(negedge push_clk);
    push       = 1'b0;
    check_full = 1'b0;
    finish_test();
  endtask

  task automatic drain_in_order();
    begin_test("drain_in_order");
    drain_all();
    repeat (4) @(negedge pop_clk);
    check_empty = 1'b1;
    repeat (2) @(negedge pop_clk);
    finish_test();
  endtask

  task automatic pop_while_empty();
    begin_test("pop_while_empty");
    repeat (4) begin
      @(negedge pop_clk);
      pop = 1'b1;
    end
    @(negedge pop_clk);
    pop         = 1'b0;
    check_empty = 1'b0;
    finish_test();
  endtask

  task automatic random_traffic();
    logic [15:0] target;
    begin_test("random_traffic");
    target = push_total + 16'(random_txns);
    fork
      begin
        @(negedge push_clk);
        while (push_total != target) begin
          push      = 1'($urandom);
          push_data = make_word(4'h4);
          @(negedge push_clk);
        end
        push = 1'b0;
      end
      begin
        @(negedge pop_clk);
        while (pop_total != target) begin
          pop = 1'($urandom);
          @(negedge pop_clk);
        end
        pop = 1'b0;
      end
    join
    finish_test();
  endtask

  task automatic mid_run_reset();
    begin_test("reset_state");
    // Entries left behind for the reset to discard
    push_items(5, 4'h5);
    @(negedge pop_clk);
    pop = 1'b1;
    @(negedge push_clk);
    push      = 1'b1;
    push_data = make_word(4'hf);
    rst_n     = 1'b0;
    repeat (10) @(negedge push_clk);
    rst_n = 1'b1;
    // Push stays high across the two edges of the release window
    @(negedge push_clk);
    push_items(depth, 4'h6);
    drain_all();
    finish_test();
  endtask

  initial begin
    #watchdog_ns;
    $display("timeout: the tests did not finish within %0d ns", watchdog_ns);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(58452));
    push_clk        = 1'b0;
    pop_clk         = 1'b0;
    push            = 1'b0;
    pop             = 1'b0;
    push_data       = '0;
    check_full      = 1'b0;
    check_empty     = 1'b0;
    test_name       = "startup";
    error_count     = 0;
    errors_at_start = 0;
    passed_tests    = 0;
    failed_tests    = 0;

    apply_reset();
    repeat (4) @(negedge pop_clk);

    fill_to_full();
    drain_in_order();
    pop_while_empty();
    random_traffic();
    mid_run_reset();

    $display("tests passed %0d, failed %0d, errors %0d",
             passed_tests, failed_tests, error_count);
    if (failed_tests == 0 && error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : cdc_fifo_tb

//--- hdl/cdc_fifo.sv
`timescale 1ns/10ps
`include "cdc_fifo_macros.svh"

// Dual-clock FIFO
// Push and pop sides exchange Gray counts through two-flop synchronizers
module cdc_fifo
  import cdc_fifo_pkg::*;
(
  input  logic           rst_n,

  // Push domain
  input  logic           push_clk,
  input  logic           push,
  input  cdc_fifo_word_t push_data,
  output push_status_t   push_stat,

  // Pop domain
  input  logic           pop_clk,
  input  logic           pop,
  output cdc_fifo_word_t pop_data,
  output pop_status_t    pop_stat
);

  localparam int addr_width = $clog2(`CDC_FIFO_DEPTH);

  count_t                push_count_gray;
  count_t                pop_count_gray;
  count_t                push_gray_at_pop;
  count_t                pop_gray_at_push;
  logic                  wr_en;
  logic [addr_width-1:0] wr_addr;
  logic [addr_width-1:0] rd_addr;

  cdc_fifo_push_flag_mgr u_push_flag_mgr (
    .clk             (push_clk),
    .rst_n           (rst_n),
    .push            (push),
    .pop_count_gray  (pop_gray_at_push),
    .push_count_gray (push_count_gray),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .stat            (push_stat)
  );

  cdc_fifo_gray_sync u_sync_to_pop (
    .clk      (pop_clk),
    .rst_n    (rst_n),
    .gray_in  (push_count_gray),
    .gray_out (push_gray_at_pop)
  );

  cdc_fifo_pop_flag_mgr u_pop_flag_mgr (
    .clk             (pop_clk),
    .rst_n           (rst_n),
    .pop             (pop),
    .push_count_gray (push_gray_at_pop),
    .pop_count_gray  (pop_count_gray),
    .rd_addr         (rd_addr),
    .stat            (pop_stat)
  );

  cdc_fifo_gray_sync u_sync_to_push (
    .clk      (push_clk),
    .rst_n    (rst_n),
    .gray_in  (pop_count_gray),
    .gray_out (pop_gray_at_push)
  );

  cdc_fifo_storage #(
    .payload_t (cdc_fifo_word_t)
  ) u_storage (
    .wr_clk  (push_clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (push_data),
    .rd_addr (rd_addr),
    .rd_data (pop_data)
  );

endmodule : cdc_fifo

//--- hdl/cdc_fifo_storage.sv
`timescale 1ns/10ps
`include "cdc_fifo_macros.svh"

// Entry array shared by the two domains
// Written on wr_clk, read without a clock so pop_data follows rd_addr
module cdc_fifo_storage
  import cdc_fifo_pkg::*;
#(
  parameter type payload_t = cdc_fifo_word_t,
  localparam int addr_width = $clog2(`CDC_FIFO_DEPTH)
) (
  input  logic                  wr_clk,
  input  logic                  wr_en,
  input  logic [addr_width-1:0] wr_addr,
  input  payload_t              wr_data,
  input  logic [addr_width-1:0] rd_addr,
  output payload_t              rd_data
);

  payload_t mem [`CDC_FIFO_DEPTH];

  // Contents are only meaningful once the write count covers them
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // The pop side only looks at entries the push side finished
  // two or more of its edges ago, so this path is stable when used
  assign rd_data = mem[rd_addr];

endmodule : cdc_fifo_storage

//--- hdl/cdc_fifo_pop_flag_mgr.sv
`timescale 1ns/10ps
`include "cdc_fifo_macros.svh"

// Pop side bookkeeping
// Decodes the synchronized push Gray count, compares it to the local
// read count for items and empty, and publishes the read count in Gray
module cdc_fifo_pop_flag_mgr
  import cdc_fifo_pkg::*;
#(
  localparam int addr_width = $clog2(`CDC_FIFO_DEPTH)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  pop,
  input  count_t                push_count_gray,
  output count_t                pop_count_gray,
  output logic [addr_width-1:0] rd_addr,
  output pop_status_t           stat
);

  localparam int count_width = `CDC_FIFO_COUNT_WIDTH;
  localparam logic [count_width:0] wrap_offset = {1'b1, count_t'(0)};

  logic   rst_sync_q1;
  logic   rst_sync_n;
  logic   rd_en;
  count_t rd_count;
  count_t push_count;

  // One extra bit so the wrap correction cannot overflow
  logic [count_width:0] push_count_ext;
  logic [count_width:0] rd_count_ext;
  logic [count_width:0] items_ext;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q1 <= 1'b0;
      rst_sync_n  <= 1'b0;
    end else begin
      rst_sync_q1 <= 1'b1;
      rst_sync_n  <= rst_sync_q1;
    end
  end

  assign push_count     = gray_to_bin(push_count_gray);
  assign push_count_ext = {1'b0, push_count};
  assign rd_count_ext   = {1'b0, rd_count};

  // Push count has wrapped past the read count when it is smaller
  assign items_ext = (push_count_ext >= rd_count_ext) ?
                     (push_count_ext - rd_count_ext) :
                     (push_count_ext + wrap_offset - rd_count_ext);

  assign stat.items = items_ext[count_width-1:0];
  assign stat.empty = (stat.items == '0);

  assign rd_en   = pop && !stat.empty && rst_sync_n;
  assign rd_addr = rd_count[addr_width-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_count <= '0;
    end else if (rd_en) begin
      rd_count <= rd_count + count_t'(1);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pop_count_gray <= '0;
    end else begin
      pop_count_gray <= bin_to_gray(rd_count);
    end
  end

  // Synchronized push count never runs more than depth ahead of reads
  items_in_range_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    items_ext <= {1'b0, count_t'(`CDC_FIFO_DEPTH)}
  ) else $error("pop side items %0d above depth", items_ext);

  // A pop against an empty FIFO leaves the read count alone
  no_pop_when_empty_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    stat.empty |=> rd_count == $past(rd_count)
  ) else $error("read count moved while empty");

  gray_one_bit_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    $countones(pop_count_gray ^ $past(pop_count_gray)) <= 1
  ) else $error("pop Gray count changed by more than one bit");

endmodule : cdc_fifo_pop_flag_mgr

//--- hdl/cdc_fifo_push_flag_mgr.sv
`timescale 1ns/10ps
`include "cdc_fifo_macros.svh"

// Push side bookkeeping
// Counts accepted pushes, publishes the count in Gray form and
// derives items and full against the synchronized pop count
module cdc_fifo_push_flag_mgr
  import cdc_fifo_pkg::*;
#(
  localparam int addr_width = $clog2(`CDC_FIFO_DEPTH)
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push,
  input  count_t                pop_count_gray,
  output count_t                push_count_gray,
  output logic                  wr_en,
  output logic [addr_width-1:0] wr_addr,
  output push_status_t          stat
);

  localparam count_t depth_count = count_t'(`CDC_FIFO_DEPTH);

  logic   rst_sync_q1;
  logic   rst_sync_n;
  count_t wr_count;
  count_t pop_count;

  // Local reset release, asserts at once and releases after two edges
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rst_sync_q1 <= 1'b0;
      rst_sync_n  <= 1'b0;
    end else begin
      rst_sync_q1 <= 1'b1;
      rst_sync_n  <= rst_sync_q1;
    end
  end

  assign pop_count = gray_to_bin(pop_count_gray);

  // Modulo subtraction, the counts wrap at the same range
  assign stat.items = wr_count - pop_count;
  assign stat.full  = (stat.items == depth_count);

  assign wr_en   = push && !stat.full && rst_sync_n;
  assign wr_addr = wr_count[addr_width-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_count <= '0;
    end else if (wr_en) begin
      wr_count <= wr_count + count_t'(1);
    end
  end

  // Published one edge after the count moves
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_count_gray <= '0;
    end else begin
      push_count_gray <= bin_to_gray(wr_count);
    end
  end

  // Pop side never reports more reads than writes
  items_in_range_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    stat.items <= depth_count
  ) else $error("push side items %0d above depth", stat.items);

  // Write count holds while full
  no_write_when_full_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    stat.full |=> wr_count == $past(wr_count)
  ) else $error("write count moved while full");

  // Only one bit of the published count may change per edge
  gray_one_bit_a: assert property (
    @(posedge clk) disable iff (!rst_n)
    $countones(push_count_gray ^ $past(push_count_gray)) <= 1
  ) else $error("push Gray count changed by more than one bit");

endmodule : cdc_fifo_push_flag_mgr

//--- hdl/cdc_fifo_gray_sync.sv
`timescale 1ns/10ps

// Brings a registered Gray count across into the clk domain
module cdc_fifo_gray_sync
  import cdc_fifo_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  count_t gray_in,
  output count_t gray_out
);

  // First stage may go metastable, never read it elsewhere
  count_t gray_meta;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gray_meta <= '0;
      gray_out  <= '0;
    end else begin
      gray_meta <= gray_in;
      gray_out  <= gray_meta;
    end
  end

endmodule : cdc_fifo_gray_sync

//--- hdl/cdc_fifo_pkg.sv
`include "cdc_fifo_macros.svh"

package cdc_fifo_pkg;

  // Binary or Gray item count
  typedef logic [`CDC_FIFO_COUNT_WIDTH-1:0] count_t;

  typedef struct packed {
    logic [3:0]                     tag;
    logic [`CDC_FIFO_DATA_WIDTH-1:0] data;
  } cdc_fifo_word_t;

  typedef struct packed {
    count_t items;
    logic   full;
  } push_status_t;

  typedef struct packed {
    count_t items;
    logic   empty;
  } pop_status_t;

  function automatic count_t bin_to_gray(count_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Each binary bit is the XOR of all Gray bits at or above it
  function automatic count_t gray_to_bin(count_t gray);
    count_t bin;
    bin[`CDC_FIFO_COUNT_WIDTH-1] = gray[`CDC_FIFO_COUNT_WIDTH-1];
    for (int i = `CDC_FIFO_COUNT_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage : cdc_fifo_pkg

//--- hdl/cdc_fifo_macros.svh
`ifndef CDC_FIFO_MACROS_SVH
`define CDC_FIFO_MACROS_SVH

// Number of FIFO entries
// Keep it a power of two so the address is the low bits of the count
`define CDC_FIFO_DEPTH 8

// Bits to count 0 through depth inclusive
// Counts wrap modulo 2**CDC_FIFO_COUNT_WIDTH
`define CDC_FIFO_COUNT_WIDTH 4

// Payload data bits, the tag is separate
`define CDC_FIFO_DATA_WIDTH 16

`endif
